//--- filelist.f
hdl/decode_pkg.sv
hdl/ctrl_decoder.sv
hdl/operand_gen.sv
hdl/preg_file.sv
hdl/greg_file.sv
hdl/decode_stage.sv
verif/tb_clock.sv
verif/decode_tb.sv

//--- Bender.yml
package:
  name: decode_stage

sources:
  - hdl/decode_pkg.sv
  - hdl/ctrl_decoder.sv
  - hdl/operand_gen.sv
  - hdl/preg_file.sv
  - hdl/greg_file.sv
  - hdl/decode_stage.sv
  - target: test
    files:
      - verif/tb_clock.sv
      - verif/decode_tb.sv

//--- verif/decode_tb.sv
module decode_tb
  import decode_pkg::*;
();

  localparam int         max_cycles  = 2000;  // ~10x the length of all tests
  localparam int         drive_delay = 2;
  localparam logic [3:0] preg_reset  = 4'b0011;  // p0 and p1 set

  logic            clk;
  logic            rst;
  inst_t           inst;
  logic [xlen-1:0] pc_n;
  logic [xlen-1:0] epc;
  wb_t             wb;
  dec_out_t        dec;

  logic [xlen-1:0] greg_shadow [16];
  logic            preg_shadow [4];
  integer          seed;
  int              errors       = 0;
  int              tests_passed = 0;
  int              tests_failed = 0;
  int              cycles       = 0;

  tb_clock u_clock (
    .clk (clk),
    .rst (rst)
  );

  decode_stage #(
    .PREG_INIT (preg_reset)
  ) dut (
    .clk  (clk),
    .rst  (rst),
    .inst (inst),
    .pc_n (pc_n),
    .epc  (epc),
    .wb   (wb),
    .dec  (dec)
  );

  // unguarded instructions always see pval high
  pval_unguarded: assert property (@(posedge clk) disable iff (rst) !inst.pset |-> dec.pval)
  else
  begin
    $display("ERROR predicate_guard pval: expected 1 actual 0 with pset low");
    errors++;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= max_cycles)
    begin
      $display("run timed out after %0d cycles", cycles);
      $display("Finished with errors");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [xlen-1:0] expected,
                             input logic [xlen-1:0] actual);
    assert (actual === expected)
    else
    begin
      $display("ERROR %s: expected %h actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #drive_delay;
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before)
    begin
      $display("test %s: pass", name);
      tests_passed++;
    end
    else
    begin
      $display("test %s: fail with %0d errors", name, errors - errors_before);
      tests_failed++;
    end
  endtask

  function automatic inst_t make_inst(input logic pset, input preg_id_t pid,
                                      input logic [5:0] op, input logic [22:0] rest);
    return {pset, pid, op, rest};
  endfunction

  // rx ry fr gr pr fm mw mr lk si, alu, pf jr jmp, imm, xz
  function automatic ctrl_t expected_ctrl(input logic [5:0] op);
    case (op)
      op_ld:     return {10'b0101010101, alu_add, 3'b100, imm_short15, 1'b0};
      op_st:     return {10'b1100001001, alu_add, 3'b100, imm_short15, 1'b1};
      op_ldi:    return {10'b0001000001, alu_ldimm, 3'b100, imm_mid19, 1'b0};
      op_addi:   return {10'b0101000001, alu_add, 3'b100, imm_short15, 1'b0};
      op_add:    return {10'b1101000000, alu_add, 3'b100, imm_none, 1'b0};
      op_neg:    return {10'b0101000000, alu_neg, 3'b100, imm_none, 1'b0};
      op_andp:   return {10'b0000100000, alu_add, 3'b000, imm_none, 1'b0};
      op_iszero: return {10'b0100100000, alu_shr, 3'b000, imm_none, 1'b0};
      op_jali:   return {10'b0001000010, alu_link, 3'b101, imm_mid19, 1'b0};
      op_jalr:   return {10'b1001000010, alu_link, 3'b111, imm_none, 1'b0};
      default:   return '0;
    endcase
  endfunction

  function automatic logic [xlen-1:0] expected_imm(input imm_sel_e sel,
                                                   input logic [22:0] f);
    case (sel)
      imm_short15: return xlen'($signed(f[14:0]));
      imm_long23:  return xlen'($signed(f[22:0]));
      imm_mid19:   return xlen'($signed(f[18:0]));
      default:     return '0;
    endcase
  endfunction

  task automatic reset_contents();
    int          errors_before;
    logic [22:0] rest;
    errors_before = errors;
    for (int i = 0; i < 16; i++)
    begin
      next_cycle();
      rest = {4'd0, 4'(i), 4'(i), 11'd0};
      inst = make_inst(1'b0, 2'd0, 6'h00, rest);
      #10;
      check_value("reset_contents rx", xlen'(i), dec.rx);
      check_value("reset_contents ry", xlen'(i), dec.ry);
      check_value("reset_contents px", xlen'(preg_reset[i % 4]), xlen'(dec.px));
    end
    next_cycle();
    inst = '0;
    #10;
    check_value("reset_contents ctrl", '0, dec.ctrl);
    check_value("reset_contents mask_cmd", mask_keep, dec.mask_cmd);
    check_value("reset_contents trap", '0, xlen'(dec.trap));
    check_value("reset_contents illegal", '0, xlen'(dec.illegal));
    report_test("reset_contents", errors_before);
  endtask

  task automatic register_writeback();
    int              errors_before;
    logic [31:0]     rnd;
    reg_id_t         w_id;
    reg_id_t         y_reg;
    preg_id_t        p_id;
    logic            p_val;
    logic [xlen-1:0] w_val;
    errors_before = errors;
    for (int n = 0; n < 20; n++)
    begin
      next_cycle();
      rnd   = $random(seed);
      w_val = $random(seed);
      w_id  = rnd[3:0];
      p_id  = rnd[5:4];
      p_val = rnd[6];
      y_reg = {rnd[9:8], p_id};  // low bits of y_id select py
      inst  = make_inst(1'b0, 2'd0, 6'h00, {4'd0, y_reg, w_id, 11'd0});
      wb    = '{p_we: 1'b1, p_id: p_id, p_val: p_val, r_we: 1'b1, r_id: w_id, r_val: w_val};
      #10;
      check_value("register_writeback old rx", greg_shadow[w_id], dec.rx);
      check_value("register_writeback old py", xlen'(preg_shadow[p_id]), xlen'(dec.py));
      greg_shadow[w_id] = w_val;
      preg_shadow[p_id] = p_val;
      next_cycle();
      wb = '0;
      #10;
      check_value("register_writeback rx", greg_shadow[w_id], dec.rx);
      check_value("register_writeback ry", greg_shadow[y_reg], dec.ry);
      check_value("register_writeback px", xlen'(preg_shadow[w_id[1:0]]), xlen'(dec.px));
      check_value("register_writeback py", xlen'(preg_shadow[p_id]), xlen'(dec.py));
    end
    report_test("register_writeback", errors_before);
  endtask

  task automatic control_table();
    int          errors_before;
    logic [5:0]  ops [10];
    logic [22:0] rest;
    ctrl_t       exp;
    errors_before = errors;
    ops = '{op_ld, op_st, op_ldi, op_addi, op_add, op_neg, op_andp, op_iszero,
            op_jali, op_jalr};
    for (int n = 0; n < 10; n++)
    begin
      next_cycle();
      rest = 23'($random(seed));
      inst = make_inst(1'b0, 2'd0, ops[n], rest);
      #10;
      exp = expected_ctrl(ops[n]);
      check_value($sformatf("control_table op %h ctrl", ops[n]), exp, dec.ctrl);
      check_value($sformatf("control_table op %h imm", ops[n]),
                  expected_imm(exp.imm_sel, rest), dec.imm);
      check_value($sformatf("control_table op %h x_id", ops[n]),
                  exp.x_from_z ? rest[22:19] : rest[14:11], dec.x_id);
      check_value($sformatf("control_table op %h y_id", ops[n]), rest[18:15], dec.y_id);
      check_value($sformatf("control_table op %h z_id", ops[n]), rest[22:19], dec.z_id);
    end
    for (int op = 6'h35; op <= 6'h39; op++)
    begin
      next_cycle();
      inst = make_inst(1'b0, 2'd0, 6'(op), 23'($random(seed)));
      #10;
      check_value($sformatf("control_table float %h ctrl", op), '0, dec.ctrl);
      check_value($sformatf("control_table float %h illegal", op), '0, xlen'(dec.illegal));
    end
    report_test("control_table", errors_before);
  endtask

  task automatic predicate_guard();
    int          errors_before;
    logic [31:0] rnd;
    logic        exp;
    errors_before = errors;
    for (int n = 0; n < 16; n++)
    begin
      next_cycle();
      rnd  = $random(seed);
      inst = make_inst(rnd[0], rnd[2:1], op_add, rnd[31:9]);
      wb   = '{p_we: rnd[6], p_id: rnd[4:3], p_val: rnd[5], r_we: 1'b0, r_id: '0, r_val: '0};
      #10;
      exp = rnd[0] ? preg_shadow[rnd[2:1]] : 1'b1;
      check_value("predicate_guard pval", xlen'(exp), xlen'(dec.pval));
      if (rnd[6])
      begin
        preg_shadow[rnd[4:3]] = rnd[5];
      end
    end
    next_cycle();
    wb = '0;
    report_test("predicate_guard", errors_before);
  endtask

  task automatic jump_target();
    int          errors_before;
    logic [22:0] rest;
    errors_before = errors;
    for (int n = 0; n < 8; n++)
    begin
      next_cycle();
      rest = 23'($random(seed));
      pc_n = $random(seed);
      inst = make_inst(1'b0, 2'd0, op_jali, rest);
      #10;
      check_value("jump_target jali", pc_n + xlen'($signed(rest[18:0])), dec.jmp_target);
      next_cycle();
      inst = make_inst(1'b0, 2'd0, op_jmpi, rest);
      #10;
      check_value("jump_target jmpi", pc_n + xlen'($signed(rest)), dec.jmp_target);
      next_cycle();
      epc  = $random(seed);
      inst = make_inst(1'b0, 2'd0, op_reti, rest);
      #10;
      check_value("jump_target reti", epc, dec.jmp_target);
    end
    report_test("jump_target", errors_before);
  endtask

  task automatic mask_and_flags();
    int        errors_before;
    mask_cmd_e exp_mask;
    errors_before = errors;
    for (int op = 0; op < 64; op++)
    begin
      next_cycle();
      inst = make_inst(1'b0, 2'd0, 6'(op), 23'($random(seed)));
      #10;
      case (op)
        'h01:    exp_mask = mask_disable;
        'h02:    exp_mask = mask_enable;
        'h2d:    exp_mask = mask_halt;
        default: exp_mask = mask_keep;
      endcase
      check_value($sformatf("mask_and_flags op %h mask_cmd", op), exp_mask, dec.mask_cmd);
      check_value($sformatf("mask_and_flags op %h trap", op), xlen'(op == 'h2e),
                  xlen'(dec.trap));
      check_value($sformatf("mask_and_flags op %h illegal", op), xlen'(op >= 'h3a),
                  xlen'(dec.illegal));
    end
    report_test("mask_and_flags", errors_before);
  endtask

  initial
  begin
    seed = 32'h6ce4_d6a4;
    inst = '0;
    pc_n = '0;
    epc  = '0;
    wb   = '0;
    @(negedge rst);
    for (int i = 0; i < 16; i++)
    begin
      greg_shadow[i] = xlen'(i);  // rN resets to N
    end
    for (int i = 0; i < 4; i++)
    begin
      preg_shadow[i] = preg_reset[i];
    end
    reset_contents();
    register_writeback();
    control_table();
    predicate_guard();
    jump_target();
    mask_and_flags();
    $display("tests passed %0d, tests failed %0d, errors %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0)
    begin
      $display("Finished with no errors");
    end
    else
    begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- verif/tb_clock.sv
module tb_clock
#(
  parameter int period       = 40,
  parameter int reset_cycles = 10
)
(
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  initial
  begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #2 rst = 1'b0;  // released just after the edge
  end

endmodule

//--- hdl/decode_stage.sv
module decode_stage
  import decode_pkg::*;
#(
  parameter logic [3:0] PREG_INIT = 4'b0011
)
(
  input  logic            clk,
  input  logic            rst,
  input  inst_t           inst,
  input  logic [xlen-1:0] pc_n,
  input  logic [xlen-1:0] epc,
  input  wb_t             wb,
  output dec_out_t        dec
);

  opcode_e         opcode;
  ctrl_t           ctrl;
  mask_cmd_e       mask_cmd;
  logic            trap;
  logic            illegal;
  reg_id_t         x_id;
  reg_id_t         y_id;
  reg_id_t         z_id;
  logic [xlen-1:0] imm;
  logic [xlen-1:0] jmp_target;
  logic [xlen-1:0] rx;
  logic [xlen-1:0] ry;
  logic            px;
  logic            py;
  logic            pval;

  assign opcode = opcode_e'(inst.opcode);  // unlisted codes fall to nop

  ctrl_decoder u_ctrl_decoder (
    .opcode   (opcode),
    .ctrl     (ctrl),
    .mask_cmd (mask_cmd),
    .trap     (trap),
    .illegal  (illegal)
  );

  operand_gen u_operand_gen (
    .inst       (inst),
    .ctrl       (ctrl),
    .pc_n       (pc_n),
    .epc        (epc),
    .x_id       (x_id),
    .y_id       (y_id),
    .z_id       (z_id),
    .imm        (imm),
    .jmp_target (jmp_target)
  );

  preg_file #(
    .PREG_INIT (PREG_INIT)
  ) u_preg_file (
    .clk  (clk),
    .rst  (rst),
    .x    (x_id[1:0]),
    .y    (y_id[1:0]),
    .pset (inst.pset),
    .pid  (inst.pid),
    .wb   (wb),
    .px   (px),
    .py   (py),
    .pval (pval)
  );

  greg_file u_greg_file (
    .clk (clk),
    .rst (rst),
    .x   (x_id),
    .y   (y_id),
    .wb  (wb),
    .rx  (rx),
    .ry  (ry)
  );

  always_comb
  begin
    dec.ctrl       = ctrl;
    dec.x_id       = x_id;
    dec.y_id       = y_id;
    dec.z_id       = z_id;
    dec.rx         = rx;
    dec.ry         = ry;
    dec.px         = px;
    dec.py         = py;
    dec.pval       = pval;
    dec.imm        = imm;
    dec.jmp_target = jmp_target;
    dec.mask_cmd   = mask_cmd;
    dec.trap       = trap;
    dec.illegal    = illegal;
  end

endmodule

//--- hdl/greg_file.sv
module greg_file
  import decode_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  reg_id_t         x,
  input  reg_id_t         y,
  input  wb_t             wb,
  output logic [xlen-1:0] rx,
  output logic [xlen-1:0] ry
);

  logic [xlen-1:0] gregs [16];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < 16; i++)
      begin
        gregs[i] <= xlen'(i);  // rN starts as N
      end
    end
    else if (wb.r_we)
    begin
      gregs[wb.r_id] <= wb.r_val;  // r0 is writable
    end
  end

  assign rx = gregs[x];
  assign ry = gregs[y];

endmodule

//--- hdl/preg_file.sv
module preg_file
  import decode_pkg::*;
#(
  parameter logic [3:0] PREG_INIT = 4'b0011
)
(
  input  logic     clk,
  input  logic     rst,
  input  preg_id_t x,
  input  preg_id_t y,
  input  logic     pset,
  input  preg_id_t pid,
  input  wb_t      wb,
  output logic     px,
  output logic     py,
  output logic     pval
);

  logic pregs [4];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < 4; i++)
      begin
        pregs[i] <= PREG_INIT[i];
      end
    end
    else if (wb.p_we)
    begin
      pregs[wb.p_id] <= wb.p_val;
    end
  end

  assign px = pregs[x];
  assign py = pregs[y];

  // unguarded instructions always execute
  assign pval = pset ? pregs[pid] : 1'b1;

endmodule

//--- hdl/operand_gen.sv
module operand_gen
  import decode_pkg::*;
(
  input  inst_t           inst,
  input  ctrl_t           ctrl,
  input  logic [xlen-1:0] pc_n,
  input  logic [xlen-1:0] epc,
  output reg_id_t         x_id,
  output reg_id_t         y_id,
  output reg_id_t         z_id,
  output logic [xlen-1:0] imm,
  output logic [xlen-1:0] jmp_target
);

  logic [22:0] field;
  logic        is_reti;

  assign field   = inst.rest;
  assign is_reti = (inst.opcode == op_reti);

  assign z_id = field[22:19];
  assign y_id = field[18:15];
  assign x_id = ctrl.x_from_z ? field[22:19] : field[14:11];

  always_comb
  begin
    case (ctrl.imm_sel)
      imm_short15: imm = {{17{field[14]}}, field[14:0]};
      imm_long23:  imm = {{9{field[22]}}, field[22:0]};
      imm_mid19:   imm = {{13{field[18]}}, field[18:0]};
      default:     imm = '0;
    endcase
  end

  // return from interrupt jumps to the saved pc
  assign jmp_target = is_reti ? epc : pc_n + imm;

endmodule

//--- hdl/ctrl_decoder.sv
module ctrl_decoder
  import decode_pkg::*;
(
  input  opcode_e   opcode,
  output ctrl_t     ctrl,
  output mask_cmd_e mask_cmd,
  output logic      trap,
  output logic      illegal
);

  always_comb
  begin
    ctrl = '0;  // nop, also float rows

    case (opcode)
      op_ld, op_st, op_addi, op_add: ctrl.alu_op = alu_add;
      op_subi, op_sub:               ctrl.alu_op = alu_sub;
      op_muli, op_mul:               ctrl.alu_op = alu_mul;
      op_divi, op_div:               ctrl.alu_op = alu_div;
      op_modi, op_mod:               ctrl.alu_op = alu_mod;
      op_shli, op_shl:               ctrl.alu_op = alu_shl;
      op_shri, op_shr:               ctrl.alu_op = alu_shr;
      op_andi, op_and:               ctrl.alu_op = alu_and;
      op_ori, op_or:                 ctrl.alu_op = alu_or;
      op_xori, op_xor:               ctrl.alu_op = alu_xor;
      op_neg:                        ctrl.alu_op = alu_neg;
      op_not:                        ctrl.alu_op = alu_not;
      op_ldi:                        ctrl.alu_op = alu_ldimm;
      op_jali, op_jalr:              ctrl.alu_op = alu_link;
      // predicate ops share codes 1..7
      op_andp:                       ctrl.alu_op = alu_add;
      op_orp:                        ctrl.alu_op = alu_sub;
      op_xorp:                       ctrl.alu_op = alu_mul;
      op_notp:                       ctrl.alu_op = alu_div;
      op_rtop:                       ctrl.alu_op = alu_mod;
      op_isneg:                      ctrl.alu_op = alu_shl;
      op_iszero:                     ctrl.alu_op = alu_shr;
      default:                       ctrl.alu_op = alu_none;
    endcase

    case (opcode)
      op_ld:
      begin
        ctrl.uses_ry     = 1'b1;
        ctrl.wb_greg     = 1'b1;
        ctrl.wb_from_mem = 1'b1;
        ctrl.mem_read    = 1'b1;
        ctrl.src2_imm    = 1'b1;
        ctrl.pf_or_i     = 1'b1;
        ctrl.imm_sel     = imm_short15;
      end
      op_st:
      begin
        ctrl.uses_rx   = 1'b1;
        ctrl.uses_ry   = 1'b1;
        ctrl.mem_write = 1'b1;
        ctrl.src2_imm  = 1'b1;
        ctrl.pf_or_i   = 1'b1;
        ctrl.imm_sel   = imm_short15;
        ctrl.x_from_z  = 1'b1;  // store data comes from the z field
      end
      op_andp, op_orp, op_xorp, op_notp:
      begin
        ctrl.wb_preg = 1'b1;
      end
      op_rtop, op_isneg, op_iszero:
      begin
        ctrl.uses_ry = 1'b1;
        ctrl.wb_preg = 1'b1;
      end
      op_ldi:
      begin
        ctrl.wb_greg  = 1'b1;
        ctrl.src2_imm = 1'b1;
        ctrl.pf_or_i  = 1'b1;
        ctrl.imm_sel  = imm_mid19;
      end
      op_andi, op_ori, op_xori, op_addi, op_subi,
      op_muli, op_divi, op_modi, op_shli, op_shri:
      begin
        ctrl.uses_ry  = 1'b1;
        ctrl.wb_greg  = 1'b1;
        ctrl.src2_imm = 1'b1;
        ctrl.pf_or_i  = 1'b1;
        ctrl.imm_sel  = imm_short15;
      end
      op_and, op_or, op_xor, op_add, op_sub,
      op_mul, op_div, op_mod, op_shl, op_shr:
      begin
        ctrl.uses_rx = 1'b1;
        ctrl.uses_ry = 1'b1;
        ctrl.wb_greg = 1'b1;
        ctrl.pf_or_i = 1'b1;
      end
      op_neg, op_not:
      begin
        ctrl.uses_ry = 1'b1;
        ctrl.wb_greg = 1'b1;
        ctrl.pf_or_i = 1'b1;
      end
      op_reti, op_jmpi:
      begin
        ctrl.is_jump = 1'b1;
        ctrl.imm_sel = imm_long23;
      end
      op_jmpr:
      begin
        ctrl.uses_rx        = 1'b1;
        ctrl.is_jump        = 1'b1;
        ctrl.jmp_reg_target = 1'b1;
        ctrl.x_from_z       = 1'b1;
      end
      op_jali:
      begin
        ctrl.wb_greg = 1'b1;
        ctrl.link    = 1'b1;
        ctrl.pf_or_i = 1'b1;
        ctrl.is_jump = 1'b1;
        ctrl.imm_sel = imm_mid19;
      end
      op_jalr:
      begin
        ctrl.uses_rx        = 1'b1;
        ctrl.wb_greg        = 1'b1;
        ctrl.link           = 1'b1;
        ctrl.pf_or_i        = 1'b1;
        ctrl.is_jump        = 1'b1;
        ctrl.jmp_reg_target = 1'b1;
      end
      default:
      begin
        ctrl.x_from_z = 1'b0;  // di, ei, halt, trap stay all zero
      end
    endcase
  end

  always_comb
  begin
    case (opcode)
      op_di:   mask_cmd = mask_disable;
      op_ei:   mask_cmd = mask_enable;
      op_halt: mask_cmd = mask_halt;
      default: mask_cmd = mask_keep;
    endcase
  end

  assign trap    = (opcode == op_trap);
  assign illegal = (opcode > 6'h39);  // past the last float slot

endmodule

//--- hdl/decode_pkg.sv
package decode_pkg;

  localparam int xlen = 32;

  typedef logic [3:0] reg_id_t;
  typedef logic [1:0] preg_id_t;

  typedef enum logic [5:0] {
    op_di     = 6'h01,
    op_ei     = 6'h02,
    op_neg    = 6'h05,
    op_not    = 6'h06,
    op_and    = 6'h07,
    op_or     = 6'h08,
    op_xor    = 6'h09,
    op_add    = 6'h0a,
    op_sub    = 6'h0b,
    op_mul    = 6'h0c,
    op_div    = 6'h0d,
    op_mod    = 6'h0e,
    op_shl    = 6'h0f,
    op_shr    = 6'h10,
    op_andi   = 6'h11,
    op_ori    = 6'h12,
    op_xori   = 6'h13,
    op_addi   = 6'h14,
    op_subi   = 6'h15,
    op_muli   = 6'h16,
    op_divi   = 6'h17,
    op_modi   = 6'h18,
    op_shli   = 6'h19,
    op_shri   = 6'h1a,
    op_jali   = 6'h1b,
    op_jalr   = 6'h1c,
    op_jmpi   = 6'h1d,
    op_jmpr   = 6'h1e,
    op_ld     = 6'h23,
    op_st     = 6'h24,
    op_ldi    = 6'h25,
    op_rtop   = 6'h26,
    op_andp   = 6'h27,
    op_orp    = 6'h28,
    op_xorp   = 6'h29,
    op_notp   = 6'h2a,
    op_isneg  = 6'h2b,
    op_iszero = 6'h2c,
    op_halt   = 6'h2d,
    op_trap   = 6'h2e,
    op_reti   = 6'h31
  } opcode_e;

  typedef enum logic [3:0] {
    alu_none  = 4'd0,
    alu_add   = 4'd1,
    alu_sub   = 4'd2,
    alu_mul   = 4'd3,
    alu_div   = 4'd4,
    alu_mod   = 4'd5,
    alu_shl   = 4'd6,
    alu_shr   = 4'd7,
    alu_and   = 4'd8,
    alu_or    = 4'd9,
    alu_xor   = 4'd10,
    alu_neg   = 4'd11,
    alu_not   = 4'd12,
    alu_ldimm = 4'd13,
    alu_link  = 4'd14
  } alu_op_e;

  typedef enum logic [1:0] {
    imm_none    = 2'd0,
    imm_short15 = 2'd1,
    imm_long23  = 2'd2,
    imm_mid19   = 2'd3
  } imm_sel_e;

  typedef enum logic [1:0] {
    mask_keep    = 2'd0,
    mask_enable  = 2'd1,
    mask_disable = 2'd2,
    mask_halt    = 2'd3
  } mask_cmd_e;

  typedef struct packed {
    logic        pset;
    preg_id_t    pid;
    logic [5:0]  opcode;
    logic [22:0] rest;
  } inst_t;

  typedef struct packed {
    logic     uses_rx;
    logic     uses_ry;
    logic     wb_freg;
    logic     wb_greg;
    logic     wb_preg;
    logic     wb_from_mem;
    logic     mem_write;
    logic     mem_read;
    logic     link;
    logic     src2_imm;
    alu_op_e  alu_op;
    logic     pf_or_i;    // 1 = integer result, 0 = predicate result
    logic     jmp_reg_target;
    logic     is_jump;
    imm_sel_e imm_sel;
    logic     x_from_z;
  } ctrl_t;

  typedef struct packed {
    logic            p_we;
    preg_id_t        p_id;
    logic            p_val;
    logic            r_we;
    reg_id_t         r_id;
    logic [xlen-1:0] r_val;
  } wb_t;

  typedef struct packed {
    ctrl_t           ctrl;
    reg_id_t         x_id;
    reg_id_t         y_id;
    reg_id_t         z_id;
    logic [xlen-1:0] rx;
    logic [xlen-1:0] ry;
    logic            px;
    logic            py;
    logic            pval;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] jmp_target;
    mask_cmd_e       mask_cmd;
    logic            trap;
    logic            illegal;
  } dec_out_t;

endpackage
